// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_touch_dri
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG) || { echo "simulation incomplete"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_clk_gen.sv
// testbench clock and reset generator with a restart request
`timescale 1ns/100ps
module tb_clk_gen #(
    parameter int PERIOD     = 8,
    parameter int RST_CYCLES = 16
) (
    input  logic rst_req,                     // sampled on the falling edge
    output logic clk,
    output logic rst_n
);

    int cnt = 0;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial rst_n = 1'b0;

    // reset held low for RST_CYCLES falling edges
    always @(negedge clk) begin
        if (rst_req) begin
            cnt   <= 0;
            rst_n <= 1'b0;
        end else if (cnt == RST_CYCLES - 1) begin
            cnt   <= cnt + 1;
            rst_n <= 1'b1;
        end else if (cnt < RST_CYCLES) begin
            cnt <= cnt + 1;
        end
    end

endmodule

// File: tb_i2c_slave.sv
// behavioural I2C master plus panel model answering exec requests with scripted bytes
`timescale 1ns/100ps
module tb_i2c_slave
    import touch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        i2c_exec,
    input  logic        i2c_rh_wl,
    input  i2c_addr_t   i2c_addr,
    input  reg_num_t    reg_num,
    input  logic [15:0] version,              // FT version register contents
    input  logic        ver_nack,             // no answer at the version register
    input  i2c_byte_t   status_byte,
    input  logic [31:0] coord_bytes,          // x lo first, in the top byte
    output i2c_byte_t   i2c_data_r,
    output logic        once_byte_done,
    output logic        i2c_done,
    output logic        i2c_ack
);

    logic [7:0] lfsr = 8'd35;

    // Fibonacci LFSR, taps 8 6 5 4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    function automatic i2c_byte_t read_byte(input i2c_addr_t addr, input int idx);
        if (addr == 16'h00A1) begin
            return (idx == 0) ? version[15:8] : version[7:0];    // high byte first
        end else if (addr == 16'h0002 || addr == 16'h814E) begin
            return status_byte;
        end
        return coord_bytes[31 - 8 * idx -: 8];
    endfunction

    task automatic serve();
        logic      rd;
        i2c_addr_t addr;
        int        num;
        int        lat;
        logic      nack;
        rd   = i2c_rh_wl;
        addr = i2c_addr;
        num  = int'(reg_num);
        lat  = 2 + rand_bits(3);              // bus latency 2..9 cycles
        nack = rd && (addr == 16'h00A1) && ver_nack;
        repeat (lat) @(negedge clk);
        if (rd && !nack) begin
            for (int i = 0; i < num; i++) begin
                i2c_data_r     = read_byte(addr, i);
                once_byte_done = 1'b1;
                @(negedge clk);
                once_byte_done = 1'b0;
                repeat (1 + rand_bits(1)) @(negedge clk);
            end
        end
        i2c_done = 1'b1;
        i2c_ack  = nack;
        @(negedge clk);
        i2c_done = 1'b0;
        i2c_ack  = 1'b0;
    endtask

    initial begin
        i2c_data_r     = '0;
        once_byte_done = 1'b0;
        i2c_done       = 1'b0;
        i2c_ack        = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n && i2c_exec) begin
                serve();
            end
        end
    end

endmodule

// File: tb_touch_dri.sv
// testbench top with the GT, FT and nack scenarios, request checks and the watchdog
`timescale 1ns/100ps
module tb_touch_dri
    import touch_pkg::*;
;

    localparam int IDLE   = 4;
    localparam int RST    = 40;
    localparam int SETTLE = 100;
    localparam int POLL   = 30;
    localparam int POLLS  = 5;                // status reads per scenario
    // three scenarios of a power-up plus polls of up to three transfers each
    localparam int WATCH_CYCLES = 3 * (16 + IDLE + RST + SETTLE + 8 * 30 + POLLS * (POLL + 100));

    logic        clk;
    logic        rst_n;
    logic        rst_req;
    slave_addr_t slave_addr;
    logic        i2c_exec;
    logic        i2c_rh_wl;
    i2c_addr_t   i2c_addr;
    i2c_byte_t   i2c_data_w;
    logic        bit_ctrl;
    reg_num_t    reg_num;
    i2c_byte_t   i2c_data_r;
    logic        once_byte_done;
    logic        i2c_done;
    logic        i2c_ack;
    logic [15:0] lcd_id;
    touch_data_t data;
    logic        touch_rst_n;
    wire         touch_int;

    logic [15:0] version_script;
    logic        ver_nack;
    i2c_byte_t   status_script;
    logic [31:0] coord_script;

    logic        ft_mode;                     // expected family
    logic [31:0] exp_data;
    logic        first_seen;
    logic        rst_q;
    logic        trst_q;
    int          cyc;
    int          up_cyc;                      // clocks since reset release
    int          rise_cyc;

    pulldown (touch_int);                     // released INT reads 0

    tb_clk_gen #(.PERIOD(8), .RST_CYCLES(16)) u_clk_gen (
        .rst_req (rst_req),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    touch_dri #(
        .IDLE_CYCLES   (IDLE),
        .RST_CYCLES    (RST),
        .SETTLE_CYCLES (SETTLE),
        .POLL_CYCLES   (POLL)
    ) u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .slave_addr     (slave_addr),
        .i2c_exec       (i2c_exec),
        .i2c_rh_wl      (i2c_rh_wl),
        .i2c_addr       (i2c_addr),
        .i2c_data_w     (i2c_data_w),
        .bit_ctrl       (bit_ctrl),
        .reg_num        (reg_num),
        .i2c_data_r     (i2c_data_r),
        .once_byte_done (once_byte_done),
        .i2c_done       (i2c_done),
        .i2c_ack        (i2c_ack),
        .lcd_id         (lcd_id),
        .data           (data),
        .touch_rst_n    (touch_rst_n),
        .touch_int      (touch_int)
    );

    tb_i2c_slave u_slave (
        .clk            (clk),
        .rst_n          (rst_n),
        .i2c_exec       (i2c_exec),
        .i2c_rh_wl      (i2c_rh_wl),
        .i2c_addr       (i2c_addr),
        .reg_num        (reg_num),
        .version        (version_script),
        .ver_nack       (ver_nack),
        .status_byte    (status_script),
        .coord_bytes    (coord_script),
        .i2c_data_r     (i2c_data_r),
        .once_byte_done (once_byte_done),
        .i2c_done       (i2c_done),
        .i2c_ack        (i2c_ack)
    );

    // ********************
    // error reporting
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        stop_on_error($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    initial begin
        #(WATCH_CYCLES * 8);
        stop_on_error("Timeout: the DUT stopped issuing the expected I2C requests");
    end

    // ********************
    // reference rules
    function automatic logic status_valid(input i2c_byte_t s, input logic ft);
        return (s[3:0] != 4'd0) && (s[3:0] <= 4'd5) && (ft || s[7]);
    endfunction

    // bytes are x lo, x hi, y lo, y hi from the top of c
    function automatic logic [31:0] coord_word(input logic [31:0] c, input logic ft);
        logic [7:0] xl;
        logic [7:0] xh;
        logic [7:0] yl;
        logic [7:0] yh;
        xl = c[31:24];
        xh = c[23:16];
        yl = c[15:8];
        yh = c[7:0];
        if (ft) begin
            return {4'd0, yl[3:0], yh, 4'd0, xl[3:0], xh};
        end
        return {xh, xl, yh, yl};
    endfunction

    always @(posedge clk) begin
        cyc    <= cyc + 1;
        rst_q  <= rst_n;                      // reset seen by the DUT this cycle
        up_cyc <= rst_n ? up_cyc + 1 : 0;
    end

    // INT strap and quiet bus while the panel is in reset
    always @(negedge clk) begin
        if (rst_q && !touch_rst_n) begin
            assert (touch_int === 1'b1) else
                stop_on_error("INT not driven high during panel reset");
            assert (!i2c_exec) else stop_on_error("exec issued while the panel is in reset");
        end
        if (touch_rst_n && !trst_q) begin
            rise_cyc = cyc;
            assert (up_cyc == IDLE + RST) else
                report_mismatch("panel reset length", 32'(IDLE + RST), 32'(up_cyc));
        end
        trst_q = touch_rst_n;
    end

    // ********************
    // request checks
    task automatic expect_req(input string name, input logic rd, input slave_addr_t sa,
                              input logic bc, input i2c_addr_t addr, input i2c_byte_t wd,
                              input reg_num_t num);
        @(negedge clk);
        while (!i2c_exec) @(negedge clk);
        if (!first_seen) begin
            first_seen = 1'b1;
            assert (cyc - rise_cyc >= SETTLE) else stop_on_error("first exec before settle time");
            assert (touch_int === 1'b0) else stop_on_error("INT still driven at first exec");
        end
        assert (i2c_rh_wl == rd) else report_mismatch({name, " dir"}, 32'(rd), 32'(i2c_rh_wl));
        assert (slave_addr == sa) else report_mismatch({name, " slave"}, 32'(sa), 32'(slave_addr));
        assert (bit_ctrl == bc) else report_mismatch({name, " bit_ctrl"}, 32'(bc), 32'(bit_ctrl));
        assert (i2c_addr == addr) else report_mismatch({name, " addr"}, 32'(addr), 32'(i2c_addr));
        assert (reg_num == num) else report_mismatch({name, " reg_num"}, 32'(num), 32'(reg_num));
        if (!rd) begin
            assert (i2c_data_w == wd) else
                report_mismatch({name, " wdata"}, 32'(wd), 32'(i2c_data_w));
        end
    endtask

    task automatic status_read(input string name);
        expect_req({name, " status"}, 1'b1, ft_mode ? 7'h38 : 7'h14, ft_mode ? 1'b0 : 1'b1,
                   ft_mode ? 16'h0002 : 16'h814E, 8'd0, 8'd1);
        assert (data == exp_data) else report_mismatch({name, " data"}, exp_data, data);
    endtask

    // one poll of a status read, the clearing write and a coordinate read when valid
    task automatic poll(input string name, input i2c_byte_t status, input logic [31:0] coords,
                        input i2c_byte_t next_status);
        status_read(name);
        coord_script = coords;
        expect_req({name, " clear"}, 1'b0, ft_mode ? 7'h38 : 7'h14, ft_mode ? 1'b0 : 1'b1,
                   ft_mode ? 16'h0002 : 16'h814E, 8'd0, 8'd1);
        status_script = next_status;
        if (status_valid(status, ft_mode)) begin
            expect_req({name, " coord"}, 1'b1, ft_mode ? 7'h38 : 7'h14, ft_mode ? 1'b0 : 1'b1,
                       ft_mode ? 16'h0003 : 16'h8150, 8'd0, 8'd4);
            exp_data = coord_word(coords, ft_mode);
        end
    endtask

    task automatic restart(input logic [15:0] id, input logic [15:0] ver, input logic nack,
                           input i2c_byte_t status, input logic ft);
        @(negedge clk);
        lcd_id         = id;
        version_script = ver;
        ver_nack       = nack;
        status_script  = status;
        ft_mode        = ft;
        @(posedge clk);
        rst_req = 1'b1;                       // taken on the next falling edge
        @(posedge clk);
        rst_req    = 1'b0;
        first_seen = 1'b0;
        exp_data   = '0;
    endtask

    task automatic probe_ft();
        logic [15:0] cfg_addr [4];
        logic [7:0]  cfg_data [4];
        cfg_addr = '{16'h0000, 16'h00A4, 16'h0080, 16'h0088};
        cfg_data = '{8'd0, 8'd0, 8'd22, 8'd12};
        expect_req("ft version", 1'b1, 7'h38, 1'b0, 16'h00A1, 8'd0, 8'd2);
        for (int i = 0; i < 4; i++) begin
            expect_req($sformatf("ft cfg %0d", i), 1'b0, 7'h38, 1'b0, cfg_addr[i],
                       cfg_data[i], 8'd1);
        end
    endtask

    initial begin
        rst_req        = 1'b0;
        lcd_id         = '0;
        version_script = '0;
        ver_nack       = 1'b0;
        status_script  = '0;
        coord_script   = '0;
        ft_mode        = 1'b0;
        exp_data       = '0;
        first_seen     = 1'b0;
        rst_q          = 1'b0;
        trst_q         = 1'b0;
        cyc            = 0;
        up_cyc         = 0;
        rise_cyc       = 0;

        // GT chosen by the LCD identifier
        restart(16'h4384, 16'h3003, 1'b0, 8'h81, 1'b0);
        poll("gt touch1", 8'h81, 32'h3412_7856, 8'h01);
        poll("gt stale", 8'h01, 32'hDEAD_BEEF, 8'h83);
        poll("gt touch2", 8'h83, 32'h9A02_BC01, 8'h86);
        poll("gt too many", 8'h86, 32'h1111_1111, 8'h00);
        status_read("gt hold");

        // FT chosen by the version read
        restart(16'h5510, 16'h3003, 1'b0, 8'h02, 1'b1);
        probe_ft();
        poll("ft touch1", 8'h02, 32'hA512_C734, 8'h00);
        poll("ft none", 8'h00, 32'h5555_5555, 8'h05);
        poll("ft touch2", 8'h05, 32'h1F2E_3D4C, 8'h00);
        status_read("ft hold");

        // nacked version read falls back to GT
        restart(16'h0000, 16'h3003, 1'b1, 8'h81, 1'b0);
        expect_req("nack version", 1'b1, 7'h38, 1'b0, 16'h00A1, 8'd0, 8'd2);
        poll("nack touch", 8'h81, 32'h0102_0304, 8'h00);
        status_read("nack hold");

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: touch_cmd_seq.sv
// FSM issuing the probe, configuration, status poll and coordinate transfers
`timescale 1ns/100ps
module touch_cmd_seq
    import touch_pkg::*;
#(
    parameter int unsigned POLL_CYCLES = DEF_POLL_CYCLES
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        power_done,
    input  logic        gt_panel,
    input  logic        ft_flag,
    input  logic        touch_valid,
    input  logic        i2c_done,
    input  logic        i2c_ack,               // high = no acknowledge
    input  logic        once_byte_done,
    output slave_addr_t slave_addr,
    output logic        i2c_exec,
    output logic        i2c_rh_wl,
    output i2c_addr_t   i2c_addr,
    output i2c_byte_t   i2c_data_w,
    output logic        bit_ctrl,
    output reg_num_t    reg_num,
    output logic        ver_hi_load,
    output logic        ver_lo_load,
    output logic        ver_nack,
    output logic        judge,
    output logic        status_load,
    output logic        coord_byte_load
);

    // one-hot phases
    localparam logic [4:0] PH_WAIT_PWR = 5'b00001;
    localparam logic [4:0] PH_PROBE    = 5'b00010;
    localparam logic [4:0] PH_CONFIG   = 5'b00100;
    localparam logic [4:0] PH_POLL     = 5'b01000;
    localparam logic [4:0] PH_COORD    = 5'b10000;

    localparam int unsigned POLL_W = $clog2(POLL_CYCLES + 1);
    localparam logic [POLL_W-1:0] POLL_LAST = POLL_W'(POLL_CYCLES - 1);

    logic [4:0]        phase;
    logic [2:0]        step;
    logic [1:0]        cfg_idx;
    logic [2:0]        byte_cnt;              // bytes seen in the current read
    logic [POLL_W-1:0] poll_cnt;
    logic              byte_ok;
    slave_addr_t       fam_slave;
    logic              fam_bit;
    i2c_addr_t         status_reg;
    i2c_addr_t         point_reg;

    assign byte_ok    = once_byte_done && !i2c_ack;
    assign fam_slave  = ft_flag ? FT_SLAVE_ADDR : GT_SLAVE_ADDR;
    assign fam_bit    = ft_flag ? FT_BIT_CTRL : GT_BIT_CTRL;
    assign status_reg = ft_flag ? FT_STATUS_REG : GT_STATUS_REG;
    assign point_reg  = ft_flag ? FT_POINT1_REG : GT_POINT1_REG;

    // ********************
    // capture strobes, valid in the cycle the byte is on i2c_data_r
    assign ver_hi_load = (phase == PH_PROBE) && (step == 3'd1) && byte_ok &&
                         (byte_cnt == 3'd0);
    assign ver_lo_load = (phase == PH_PROBE) && (step == 3'd1) && byte_ok &&
                         (byte_cnt == 3'd1);
    assign ver_nack        = (phase == PH_PROBE) && (step == 3'd1) && i2c_done && i2c_ack;
    assign status_load     = (phase == PH_POLL) && (step == 3'd2) && byte_ok;
    assign coord_byte_load = (phase == PH_COORD) && (step == 3'd1) && byte_ok;

    // load one request and fire exec
    task automatic issue(input slave_addr_t sa, input logic bc, input logic rd,
                         input i2c_addr_t addr, input i2c_byte_t wdata,
                         input reg_num_t num);
        slave_addr <= sa;
        bit_ctrl   <= bc;
        i2c_rh_wl  <= rd;
        i2c_addr   <= addr;
        i2c_data_w <= wdata;
        reg_num    <= num;
        i2c_exec   <= 1'b1;
        byte_cnt   <= '0;
    endtask

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase      <= PH_WAIT_PWR;
            step       <= '0;
            cfg_idx    <= '0;
            byte_cnt   <= '0;
            poll_cnt   <= '0;
            judge      <= 1'b0;
            slave_addr <= '0;
            i2c_exec   <= 1'b0;
            i2c_rh_wl  <= 1'b0;
            i2c_addr   <= '0;
            i2c_data_w <= '0;
            bit_ctrl   <= 1'b0;
            reg_num    <= '0;
        end else begin
            i2c_exec <= 1'b0;                 // single-cycle pulses
            judge    <= 1'b0;
            if (once_byte_done) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
            case (phase)
                PH_WAIT_PWR: begin
                    if (power_done) begin
                        phase <= PH_PROBE;
                        step  <= 3'd0;
                    end
                end
                PH_PROBE: begin
                    case (step)
                        3'd0: begin
                            if (gt_panel) begin
                                judge <= 1'b1;    // lcd id already decides
                                step  <= 3'd2;
                            end else begin
                                issue(FT_SLAVE_ADDR, FT_BIT_CTRL, 1'b1, FT_VERSION_REG,
                                      8'd0, FT_VERSION_LEN);
                                step <= 3'd1;
                            end
                        end
                        3'd1: begin
                            if (i2c_done) begin
                                judge <= 1'b1;
                                step  <= 3'd2;
                            end
                        end
                        3'd2: step <= 3'd3;       // ft_flag settles here
                        default: begin
                            step  <= 3'd0;
                            phase <= ft_flag ? PH_CONFIG : PH_POLL;
                        end
                    endcase
                end
                PH_CONFIG: begin
                    if (step == 3'd0) begin
                        issue(FT_SLAVE_ADDR, FT_BIT_CTRL, 1'b0, FT_CFG_ADDR[cfg_idx],
                              FT_CFG_DATA[cfg_idx], 8'd1);
                        step <= 3'd1;
                    end else if (i2c_done) begin
                        step <= 3'd0;             // nack repeats the same entry
                        if (!i2c_ack) begin
                            cfg_idx <= cfg_idx + 1'b1;
                            if (cfg_idx == 2'd3) begin
                                phase <= PH_POLL;
                            end
                        end
                    end
                end
                PH_POLL: begin
                    case (step)
                        3'd0: begin
                            if (poll_cnt == POLL_LAST) begin
                                poll_cnt <= '0;
                                step     <= 3'd1;
                            end else begin
                                poll_cnt <= poll_cnt + 1'b1;
                            end
                        end
                        3'd1: begin
                            issue(fam_slave, fam_bit, 1'b1, status_reg, 8'd0, 8'd1);
                            step <= 3'd2;
                        end
                        3'd2: begin
                            if (i2c_done) begin
                                step <= i2c_ack ? 3'd1 : 3'd3;
                            end
                        end
                        3'd3: begin
                            issue(fam_slave, fam_bit, 1'b0, status_reg, 8'd0, 8'd1);
                            step <= 3'd4;         // clear the status register
                        end
                        default: begin
                            if (i2c_done) begin
                                if (i2c_ack) begin
                                    step <= 3'd3;
                                end else begin
                                    step <= 3'd0;
                                    if (touch_valid) begin
                                        phase <= PH_COORD;
                                    end
                                end
                            end
                        end
                    endcase
                end
                PH_COORD: begin
                    if (step == 3'd0) begin
                        issue(fam_slave, fam_bit, 1'b1, point_reg, 8'd0, 8'd4);
                        step <= 3'd1;
                    end else if (i2c_done) begin
                        step <= 3'd0;             // nack restarts the read
                        if (!i2c_ack) begin
                            phase <= PH_POLL;
                        end
                    end
                end
                default: begin
                    phase <= PH_WAIT_PWR;
                    step  <= 3'd0;
                end
            endcase
        end
    end

endmodule

// File: touch_dri.sv
// touch panel controller top: power-up, family select, command FSM and report
`timescale 1ns/100ps
module touch_dri
    import touch_pkg::*;
#(
    parameter int unsigned IDLE_CYCLES   = DEF_IDLE_CYCLES,
    parameter int unsigned RST_CYCLES    = DEF_RST_CYCLES,
    parameter int unsigned SETTLE_CYCLES = DEF_SETTLE_CYCLES,
    parameter int unsigned POLL_CYCLES   = DEF_POLL_CYCLES
) (
    input  logic        clk,
    input  logic        rst_n,
    // I2C master request side
    output slave_addr_t slave_addr,
    output logic        i2c_exec,
    output logic        i2c_rh_wl,
    output i2c_addr_t   i2c_addr,
    output i2c_byte_t   i2c_data_w,
    output logic        bit_ctrl,
    output reg_num_t    reg_num,
    input  i2c_byte_t   i2c_data_r,
    input  logic        once_byte_done,
    input  logic        i2c_done,
    input  logic        i2c_ack,
    // panel side
    input  logic [15:0] lcd_id,
    output touch_data_t data,
    output logic        touch_rst_n,
    inout  wire         touch_int
);

    logic power_done;
    logic gt_panel;
    logic ft_flag;
    logic ver_hi_load;
    logic ver_lo_load;
    logic ver_nack;
    logic judge;
    logic status_load;
    logic coord_byte_load;
    logic touch_valid;

    touch_power_seq #(
        .IDLE_CYCLES   (IDLE_CYCLES),
        .RST_CYCLES    (RST_CYCLES),
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) u_power_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .touch_rst_n (touch_rst_n),
        .touch_int   (touch_int),
        .power_done  (power_done)
    );

    touch_family_sel u_family_sel (
        .clk         (clk),
        .rst_n       (rst_n),
        .lcd_id      (lcd_id),
        .i2c_data_r  (i2c_data_r),
        .ver_hi_load (ver_hi_load),
        .ver_lo_load (ver_lo_load),
        .ver_nack    (ver_nack),
        .judge       (judge),
        .gt_panel    (gt_panel),
        .ft_flag     (ft_flag)
    );

    touch_cmd_seq #(
        .POLL_CYCLES (POLL_CYCLES)
    ) u_cmd_seq (
        .clk             (clk),
        .rst_n           (rst_n),
        .power_done      (power_done),
        .gt_panel        (gt_panel),
        .ft_flag         (ft_flag),
        .touch_valid     (touch_valid),
        .i2c_done        (i2c_done),
        .i2c_ack         (i2c_ack),
        .once_byte_done  (once_byte_done),
        .slave_addr      (slave_addr),
        .i2c_exec        (i2c_exec),
        .i2c_rh_wl       (i2c_rh_wl),
        .i2c_addr        (i2c_addr),
        .i2c_data_w      (i2c_data_w),
        .bit_ctrl        (bit_ctrl),
        .reg_num         (reg_num),
        .ver_hi_load     (ver_hi_load),
        .ver_lo_load     (ver_lo_load),
        .ver_nack        (ver_nack),
        .judge           (judge),
        .status_load     (status_load),
        .coord_byte_load (coord_byte_load)
    );

    touch_report u_report (
        .clk             (clk),
        .rst_n           (rst_n),
        .ft_flag         (ft_flag),
        .status_load     (status_load),
        .coord_byte_load (coord_byte_load),
        .i2c_data_r      (i2c_data_r),
        .touch_valid     (touch_valid),
        .data            (data)
    );

endmodule

// File: touch_family_sel.sv
// FT/GT family decision from the LCD identifier and the FT version bytes
`timescale 1ns/100ps
module touch_family_sel
    import touch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] lcd_id,
    input  i2c_byte_t   i2c_data_r,
    input  logic        ver_hi_load,
    input  logic        ver_lo_load,
    input  logic        ver_nack,
    input  logic        judge,
    output logic        gt_panel,
    output logic        ft_flag
);

    localparam logic [15:0] NACK_VERSION = 16'h4754;  // "GT", not in the FT table

    logic [15:0] version;
    logic        ft_version;

    always_comb begin
        gt_panel = 1'b0;
        for (int i = 0; i < NUM_GT_IDS; i++) begin
            if (lcd_id == GT_LCD_IDS[i]) begin
                gt_panel = 1'b1;
            end
        end
    end

    always_comb begin
        ft_version = 1'b0;
        for (int i = 0; i < NUM_FT_VERSIONS; i++) begin
            if (version == FT_VERSIONS[i]) begin
                ft_version = 1'b1;
            end
        end
    end

    // version bytes arrive high first
    always_ff @(posedge clk) begin
        if (ver_nack) begin
            version <= NACK_VERSION;          // no answer at the FT address
        end else if (ver_hi_load) begin
            version[15:8] <= i2c_data_r;
        end else if (ver_lo_load) begin
            version[7:0] <= i2c_data_r;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ft_flag <= 1'b0;
        end else if (judge) begin
            ft_flag <= !gt_panel && ft_version;
        end
    end

endmodule

// File: touch_pkg.sv
// bus types, register map, family tables and default delays for the touch controller
package touch_pkg;

    // ********************
    // bus and payload types
    typedef logic [7:0]  i2c_byte_t;          // one data byte
    typedef logic [15:0] i2c_addr_t;          // register address
    typedef logic [6:0]  slave_addr_t;        // 7-bit device address
    typedef logic [7:0]  reg_num_t;           // bytes per transfer
    typedef logic [15:0] coord_t;             // one axis

    typedef struct packed {
        coord_t x;                            // upper half
        coord_t y;
    } touch_data_t;

    // ********************
    // device addressing
    localparam slave_addr_t FT_SLAVE_ADDR = 7'h38;
    localparam slave_addr_t GT_SLAVE_ADDR = 7'h14;
    localparam logic        FT_BIT_CTRL   = 1'b0;     // 8-bit register address
    localparam logic        GT_BIT_CTRL   = 1'b1;     // 16-bit register address

    localparam i2c_addr_t FT_VERSION_REG = 16'h00A1;
    localparam reg_num_t  FT_VERSION_LEN = 8'd2;      // version is two bytes
    localparam i2c_addr_t FT_STATUS_REG  = 16'h0002;
    localparam i2c_addr_t GT_STATUS_REG  = 16'h814E;
    localparam i2c_addr_t FT_POINT1_REG  = 16'h0003;
    localparam i2c_addr_t GT_POINT1_REG  = 16'h8150;

    // ********************
    // FT configuration writes, entry 0 goes out first
    localparam int NUM_FT_CFG = 4;
    localparam i2c_addr_t [NUM_FT_CFG-1:0] FT_CFG_ADDR =
        {16'h0088, 16'h0080, 16'h00A4, 16'h0000}; // period, threshold, int mode, device mode
    localparam i2c_byte_t [NUM_FT_CFG-1:0] FT_CFG_DATA =
        {8'd12, 8'd22, 8'd0, 8'd0};

    // family tables
    localparam int NUM_GT_IDS = 3;
    localparam logic [NUM_GT_IDS-1:0][15:0] GT_LCD_IDS = {16'h1018, 16'h4342, 16'h4384};
    localparam int NUM_FT_VERSIONS = 4;
    localparam logic [NUM_FT_VERSIONS-1:0][15:0] FT_VERSIONS =
        {16'h0000, 16'h0002, 16'h0001, 16'h3003};

    localparam logic [3:0] MAX_POINTS = 4'd5;         // highest legal touch count

    // ********************
    // default delays in clock cycles
    localparam int unsigned DEF_IDLE_CYCLES   = 10;
    localparam int unsigned DEF_RST_CYCLES    = 10_000;
    localparam int unsigned DEF_SETTLE_CYCLES = 50_000;
    localparam int unsigned DEF_POLL_CYCLES   = 20_000;

endpackage

// File: touch_power_seq.sv
// power-up timer driving the panel reset line and the INT strap
`timescale 1ns/100ps
module touch_power_seq
    import touch_pkg::*;
#(
    parameter int unsigned IDLE_CYCLES   = DEF_IDLE_CYCLES,
    parameter int unsigned RST_CYCLES    = DEF_RST_CYCLES,
    parameter int unsigned SETTLE_CYCLES = DEF_SETTLE_CYCLES
) (
    input  logic clk,
    input  logic rst_n,
    output logic touch_rst_n,
    inout  wire  touch_int,
    output logic power_done
);

    // one counter walks idle, reset-low and settle back to back
    localparam int unsigned TOTAL = IDLE_CYCLES + RST_CYCLES + SETTLE_CYCLES;
    localparam int unsigned CNT_W = $clog2(TOTAL + 1);
    localparam logic [CNT_W-1:0] RST_END  = CNT_W'(IDLE_CYCLES + RST_CYCLES - 1);
    localparam logic [CNT_W-1:0] LAST     = CNT_W'(TOTAL - 1);
    localparam logic [CNT_W-1:0] DONE_CNT = CNT_W'(TOTAL);

    logic [CNT_W-1:0] cnt;
    logic             int_oe;                 // INT driven high while set

    assign touch_int = int_oe ? 1'b1 : 1'bz;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt         <= '0;
            int_oe      <= 1'b0;
            touch_rst_n <= 1'b0;
            power_done  <= 1'b0;
        end else if (cnt != DONE_CNT) begin
            cnt        <= cnt + 1'b1;
            int_oe     <= (cnt != LAST);      // released with power_done
            power_done <= (cnt == LAST);
            if (cnt == RST_END) begin
                touch_rst_n <= 1'b1;          // end of reset-low phase
            end
        end else begin
            power_done <= 1'b0;               // counter parks here
        end
    end

endmodule

// File: touch_report.sv
// status decoding, coordinate assembly with FT reordering and the output register
`timescale 1ns/100ps
module touch_report
    import touch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ft_flag,
    input  logic        status_load,
    input  logic        coord_byte_load,
    input  i2c_byte_t   i2c_data_r,
    output logic        touch_valid,
    output touch_data_t data
);

    i2c_byte_t   coord_byte [4];              // x lo, x hi, y lo, y hi
    logic [1:0]  byte_idx;
    logic        coord_full;                  // all four bytes held
    logic [3:0]  points;
    coord_t      x_raw;
    coord_t      y_raw;
    touch_data_t data_next;

    assign points = i2c_data_r[3:0];
    assign x_raw  = {coord_byte[1], coord_byte[0]};
    assign y_raw  = {coord_byte[3], coord_byte[2]};

    // FT swaps axes and keeps only 12 bits
    always_comb begin
        if (ft_flag) begin
            data_next.x = {4'd0, y_raw[3:0], y_raw[15:8]};
            data_next.y = {4'd0, x_raw[3:0], x_raw[15:8]};
        end else begin
            data_next.x = x_raw;
            data_next.y = y_raw;
        end
    end

    always_ff @(posedge clk) begin
        if (coord_byte_load) begin
            coord_byte[byte_idx] <= i2c_data_r;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            touch_valid <= 1'b0;
            byte_idx    <= '0;
            coord_full  <= 1'b0;
            data        <= '0;
        end else begin
            coord_full <= coord_byte_load && (byte_idx == 2'd3);
            if (status_load) begin
                // GT also flags a fresh buffer in bit 7
                touch_valid <= (points != 4'd0) && (points <= MAX_POINTS) &&
                               (ft_flag || i2c_data_r[7]);
                byte_idx    <= '0;
            end else if (coord_byte_load) begin
                byte_idx <= byte_idx + 1'b1;
            end
            if (coord_full) begin
                data <= data_next;
            end
        end
    end

endmodule

// File: vlog.f
touch_pkg.sv
touch_power_seq.sv
touch_family_sel.sv
touch_cmd_seq.sv
touch_report.sv
touch_dri.sv
tb_clk_gen.sv
tb_i2c_slave.sv
tb_touch_dri.sv
